/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - source/mipsPkg.sv
  - source/instrFetch.sv
  - source/instrDecode.sv
  - source/regFile.sv
  - source/hazardForward.sv
  - source/execStage.sv
  - source/memWriteback.sv
  - source/mipsPipeline.sv
  - target: simulation
    files:
      - verif/mipsPipelineTb.sv

/* sim.f */
source/mipsPkg.sv
source/instrFetch.sv
source/instrDecode.sv
source/regFile.sv
source/hazardForward.sv
source/execStage.sv
source/memWriteback.sv
source/mipsPipeline.sv
verif/mipsPipelineTb.sv

/* source/execStage.sv */
module execStage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    input  mipsPkg::idExCtrl_t  idExCtrl,
    input  mipsPkg::word_t      readA,
    input  mipsPkg::word_t      readB,
    input  mipsPkg::fwdSel_t    fwdSelA,
    input  mipsPkg::fwdSel_t    fwdSelB,
    input  mipsPkg::wbPort_t    wbPort,
    output mipsPkg::exMem_t     exMem
);
    import mipsPkg::*;

    word_t  opA;
    word_t  opB;
    word_t  aluB;
    word_t  aluOut;
    exMem_t exMemNext;

    function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal,
                                     input word_t memVal, input word_t wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA  = fwdMux(fwdSelA, readA, exMem.aluResult, wbPort.data);
    assign opB  = fwdMux(fwdSelB, readB, exMem.aluResult, wbPort.data);
    assign aluB = idExCtrl.useImm ? idExCtrl.imm : opB;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (idExCtrl.aluOp)
            aluAdd:  aluOut = opA + aluB;
            aluSub:  aluOut = opA - aluB;
            aluAnd:  aluOut = opA & aluB;
            aluOr:   aluOut = opA | aluB;
            // signed compare
            aluSlt:  aluOut = ($signed(opA) < $signed(aluB)) ? word_t'(1) : '0;
            default: aluOut = '0;
        endcase
    end

    always_comb begin
        exMemNext.aluResult = aluOut;
        // store data is rt after forwarding
        exMemNext.storeData = opB;
        exMemNext.dest      = idExCtrl.dest;
        exMemNext.regWrite  = idExCtrl.regWrite;
        exMemNext.memRead   = idExCtrl.memRead;
        exMemNext.memWrite  = idExCtrl.memWrite;
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem <= '0;
        end else if (advance) begin
            exMem <= exMemNext;
        end
    end

endmodule

/* source/hazardForward.sv */
module hazardForward (
    input  logic                iCacheStall,
    input  logic                dCacheStall,
    input  mipsPkg::word_t      instr,
    input  mipsPkg::idExCtrl_t  idExCtrl,
    input  mipsPkg::exMem_t     exMem,
    input  mipsPkg::wbPort_t    wbPort,
    output logic                advance,
    output logic                loadStall,
    output mipsPkg::fwdSel_t    fwdSelA,
    output mipsPkg::fwdSel_t    fwdSelB
);
    import mipsPkg::*;

    regAddr_t ifRs;
    regAddr_t ifRt;

    assign ifRs = instr[25:21];
    assign ifRt = instr[20:16];

    // either cache stall freezes the whole pipe
    assign advance = !(iCacheStall || dCacheStall);

    // load in ID/EX feeding the instruction in IF/ID
    assign loadStall = idExCtrl.memRead && idExCtrl.dest != '0
                       && (idExCtrl.dest == ifRs || idExCtrl.dest == ifRt);

    // EX/MEM result wins over writeback; loads in EX/MEM have no data yet
    function automatic fwdSel_t pickFwd(input regAddr_t src, input exMem_t memEntry,
                                        input wbPort_t wb);
        if (memEntry.regWrite && !memEntry.memRead && memEntry.dest != '0
            && memEntry.dest == src) begin
            return fwdMem;
        end else if (wb.en && wb.addr != '0 && wb.addr == src) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    assign fwdSelA = pickFwd(idExCtrl.rs, exMem, wbPort);
    assign fwdSelB = pickFwd(idExCtrl.rt, exMem, wbPort);

endmodule

/* source/instrDecode.sv */
module instrDecode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    input  logic                loadStall,
    input  mipsPkg::word_t      instr,
    output mipsPkg::idExCtrl_t  idExCtrl
);
    import mipsPkg::*;

    opcode_t   opcode;
    funct_t    funct;
    regAddr_t  rs;
    regAddr_t  rt;
    regAddr_t  rd;
    idExCtrl_t decoded;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        decoded      = '0;
        decoded.rs   = rs;
        decoded.rt   = rt;
        // sign-extended immediate
        decoded.imm  = {{(dataWidth-16){instr[15]}}, instr[15:0]};
        case (opcode)
            rType: begin
                decoded.dest     = rd;
                decoded.regWrite = 1'b1;
                case (funct)
                    fnAdd:   decoded.aluOp = aluAdd;
                    fnSub:   decoded.aluOp = aluSub;
                    fnAnd:   decoded.aluOp = aluAnd;
                    fnOr:    decoded.aluOp = aluOr;
                    fnSlt:   decoded.aluOp = aluSlt;
                    // unknown funct, incl. the all-zero nop
                    default: decoded = '0;
                endcase
            end
            addi: begin
                decoded.dest     = rt;
                decoded.useImm   = 1'b1;
                decoded.regWrite = 1'b1;
            end
            lw: begin
                decoded.dest     = rt;
                decoded.useImm   = 1'b1;
                decoded.regWrite = 1'b1;
                decoded.memRead  = 1'b1;
            end
            sw: begin
                // no destination for a store
                decoded.useImm   = 1'b1;
                decoded.memWrite = 1'b1;
            end
            default: decoded = '0;
        endcase
    end

    // ID/EX control register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idExCtrl <= '0;
        end else if (advance) begin
            // bubble while the consumer waits on a load
            idExCtrl <= loadStall ? '0 : decoded;
        end
    end

endmodule

/* source/instrFetch.sv */
module instrFetch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              advance,
    input  logic              loadStall,
    input  mipsPkg::word_t    iCacheRdata,
    output mipsPkg::wordAddr_t iCacheAddr,
    output mipsPkg::word_t    instr
);
    import mipsPkg::*;

    word_t pc;
    logic  fetchEn;

    // pc and IF/ID move together, held by cache stall or load-use
    assign fetchEn = advance && !loadStall;

    // byte pc to word address
    assign iCacheAddr = pc[dataWidth-1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (fetchEn) begin
            pc <= pc + word_t'(pcStep);
        end
    end

    // IF/ID instruction register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr <= '0;
        end else if (fetchEn) begin
            instr <= iCacheRdata;
        end
    end

endmodule

/* source/memWriteback.sv */
module memWriteback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    input  mipsPkg::exMem_t     exMem,
    input  mipsPkg::word_t      dCacheRdata,
    output mipsPkg::dCacheReq_t dCacheReq,
    output mipsPkg::wbPort_t    wbPort
);
    import mipsPkg::*;

    memWb_t memWb;

    // data cache request straight from EX/MEM
    assign dCacheReq.ren   = exMem.memRead;
    assign dCacheReq.wen   = exMem.memWrite;
    assign dCacheReq.addr  = exMem.aluResult[dataWidth-1:2];
    assign dCacheReq.wdata = exMem.storeData;

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memWb <= '0;
        end else if (advance) begin
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData  <= dCacheRdata;
            memWb.dest      <= exMem.dest;
            memWb.regWrite  <= exMem.regWrite;
            memWb.memRead   <= exMem.memRead;
        end
    end

    // no register write while the pipe is held
    assign wbPort.en   = memWb.regWrite && advance;
    assign wbPort.addr = memWb.dest;
    assign wbPort.data = memWb.memRead ? memWb.loadData : memWb.aluResult;

endmodule

/* source/mipsPipeline.sv */
module mipsPipeline (
    input  logic                clk,
    input  logic                rst_n,
    output mipsPkg::wordAddr_t  iCacheAddr,
    input  mipsPkg::word_t      iCacheRdata,
    input  logic                iCacheStall,
    output mipsPkg::dCacheReq_t dCacheReq,
    input  mipsPkg::word_t      dCacheRdata,
    input  logic                dCacheStall
);
    import mipsPkg::*;

    logic      advance;
    logic      loadStall;
    word_t     instr;
    idExCtrl_t idExCtrl;
    word_t     readA;
    word_t     readB;
    fwdSel_t   fwdSelA;
    fwdSel_t   fwdSelB;
    exMem_t    exMem;
    wbPort_t   wbPort;

    //////////////////////////////////////////////////////////////////////
    // fetch
    //////////////////////////////////////////////////////////////////////

    instrFetch uFetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .loadStall   (loadStall),
        .iCacheRdata (iCacheRdata),
        .iCacheAddr  (iCacheAddr),
        .instr       (instr)
    );

    //////////////////////////////////////////////////////////////////////
    // decode and operand read, side by side
    //////////////////////////////////////////////////////////////////////

    instrDecode uDecode (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .loadStall (loadStall),
        .instr     (instr),
        .idExCtrl  (idExCtrl)
    );

    regFile uRegFile (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .loadStall (loadStall),
        .instr     (instr),
        .wbPort    (wbPort),
        .readA     (readA),
        .readB     (readB)
    );

    hazardForward uHazard (
        .iCacheStall (iCacheStall),
        .dCacheStall (dCacheStall),
        .instr       (instr),
        .idExCtrl    (idExCtrl),
        .exMem       (exMem),
        .wbPort      (wbPort),
        .advance     (advance),
        .loadStall   (loadStall),
        .fwdSelA     (fwdSelA),
        .fwdSelB     (fwdSelB)
    );

    //////////////////////////////////////////////////////////////////////
    // execute, memory, writeback
    //////////////////////////////////////////////////////////////////////

    execStage uExec (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .idExCtrl (idExCtrl),
        .readA    (readA),
        .readB    (readB),
        .fwdSelA  (fwdSelA),
        .fwdSelB  (fwdSelB),
        .wbPort   (wbPort),
        .exMem    (exMem)
    );

    memWriteback uMemWb (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .exMem       (exMem),
        .dCacheRdata (dCacheRdata),
        .dCacheReq   (dCacheReq),
        .wbPort      (wbPort)
    );

endmodule

/* source/mipsPkg.sv */
package mipsPkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int dataWidth     = 32;
    localparam int regAddrWidth  = 5;
    localparam int wordAddrWidth = 30;
    localparam int pcStep        = 4;

    typedef logic [dataWidth-1:0]     word_t;
    typedef logic [regAddrWidth-1:0]  regAddr_t;
    typedef logic [wordAddrWidth-1:0] wordAddr_t;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        rType = 6'h00,
        addi  = 6'h08,
        lw    = 6'h23,
        sw    = 6'h2b
    } opcode_t;

    // funct field of r-type, bits 5:0
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_t;

    typedef enum logic [1:0] {
        fwdNone,
        fwdMem,
        fwdWb
    } fwdSel_t;

    //////////////////////////////////////////////////////////////////////
    // stage contents
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        aluOp_t   aluOp;
        logic     useImm;
        word_t    imm;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
    } idExCtrl_t;

    typedef struct packed {
        word_t    aluResult;
        word_t    storeData;
        regAddr_t dest;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
    } exMem_t;

    typedef struct packed {
        word_t    aluResult;
        word_t    loadData;
        regAddr_t dest;
        logic     regWrite;
        logic     memRead;
    } memWb_t;

    typedef struct packed {
        logic      ren;
        logic      wen;
        wordAddr_t addr;
        word_t     wdata;
    } dCacheReq_t;

    typedef struct packed {
        logic     en;
        regAddr_t addr;
        word_t    data;
    } wbPort_t;

endpackage

/* source/regFile.sv */
module regFile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             advance,
    input  logic             loadStall,
    input  mipsPkg::word_t   instr,
    input  mipsPkg::wbPort_t wbPort,
    output mipsPkg::word_t   readA,
    output mipsPkg::word_t   readB
);
    import mipsPkg::*;

    word_t    regs [2**regAddrWidth];
    regAddr_t rs;
    regAddr_t rt;

    assign rs = instr[25:21];
    assign rt = instr[20:16];

    // write-first read, r0 hardwired to zero
    function automatic word_t readReg(input regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wbPort.en && wbPort.addr == addr) begin
            return wbPort.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
            readA <= '0;
            readB <= '0;
        end else begin
            // wbPort.en already drops while the pipe is held
            if (wbPort.en && wbPort.addr != '0) begin
                regs[wbPort.addr] <= wbPort.data;
            end
            if (advance && !loadStall) begin
                readA <= readReg(rs);
                readB <= readReg(rt);
            end
        end
    end

endmodule

/* verif/mipsPipelineTb.sv */
module mipsPipelineTb;
    import mipsPkg::*;

    localparam int clkPeriod   = 100;
    localparam int maxRows     = 64;
    localparam int memDepth    = 256;
    localparam int drainCycles = 12;

    // instruction set encodings
    localparam logic [5:0] isaOpR    = 6'h00;
    localparam logic [5:0] isaOpAddi = 6'h08;
    localparam logic [5:0] isaOpLw   = 6'h23;
    localparam logic [5:0] isaOpSw   = 6'h2b;
    localparam logic [5:0] isaFnAdd  = 6'h20;
    localparam logic [5:0] isaFnSub  = 6'h22;
    localparam logic [5:0] isaFnAnd  = 6'h24;
    localparam logic [5:0] isaFnOr   = 6'h25;
    localparam logic [5:0] isaFnSlt  = 6'h2a;

    typedef struct packed {
        word_t     instr;
        logic      expStore;
        wordAddr_t expAddr;
        word_t     expData;
    } row_t;

    logic       clk;
    logic       rst_n;
    wordAddr_t  iCacheAddr;
    word_t      iCacheRdata;
    logic       iCacheStall;
    dCacheReq_t dCacheReq;
    word_t      dCacheRdata;
    logic       dCacheStall;

    row_t   rows [maxRows];
    string  rowNames [maxRows];
    int     storeRows [maxRows];
    int     rowCount    = 0;
    int     expectCount = 0;
    int     storeCount  = 0;
    int     expectLoads = 0;
    int     loadCount   = 0;
    int     checkCount  = 0;
    int     errorCount  = 0;
    int     cycleCount  = 0;
    integer seed        = 10846;
    word_t  dataMem [memDepth];
    word_t  refMem [memDepth];

    mipsPipeline DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .iCacheAddr  (iCacheAddr),
        .iCacheRdata (iCacheRdata),
        .iCacheStall (iCacheStall),
        .dCacheReq   (dCacheReq),
        .dCacheRdata (dCacheRdata),
        .dCacheStall (dCacheStall)
    );

    // cache models answer in the same cycle, nops past the program
    assign iCacheRdata = (iCacheAddr < wordAddr_t'(rowCount)) ? rows[iCacheAddr[5:0]].instr : '0;
    assign dCacheRdata = dataMem[dCacheReq.addr[7:0]];

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // program and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic word_t rInstr(input logic [5:0] funct, input int rd, input int rs,
                                     input int rt);
        return {isaOpR, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic word_t iInstr(input logic [5:0] op, input int rt, input int rs,
                                     input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // every index bit shows up in the word
    function automatic word_t fillWord(input int idx);
        return (word_t'(idx) * 32'h0101_0101) ^ 32'h5A3C_0F00;
    endfunction

    task automatic addRow(input string name, input word_t instr);
        rowNames[rowCount] = name;
        rows[rowCount] = '0;
        rows[rowCount].instr = instr;
        rowCount++;
    endtask

    task automatic buildProgram();
        addRow("addi r1 25", iInstr(isaOpAddi, 1, 0, 25));
        addRow("addi r2 -7", iInstr(isaOpAddi, 2, 0, -7));
        addRow("sw r2 after addi", iInstr(isaOpSw, 2, 0, 0));
        addRow("addi r3 -100", iInstr(isaOpAddi, 3, 0, -100));
        addRow("add r4 r1 r2", rInstr(isaFnAdd, 4, 1, 2));
        addRow("sw add", iInstr(isaOpSw, 4, 0, 4));
        addRow("sub r5 r2 r1", rInstr(isaFnSub, 5, 2, 1));
        addRow("sw sub", iInstr(isaOpSw, 5, 0, 8));
        addRow("and r6 r3 r2", rInstr(isaFnAnd, 6, 3, 2));
        addRow("sw and", iInstr(isaOpSw, 6, 0, 12));
        addRow("or r7 r3 r1", rInstr(isaFnOr, 7, 3, 1));
        addRow("sw or", iInstr(isaOpSw, 7, 0, 16));
        addRow("slt r8 r3 r2", rInstr(isaFnSlt, 8, 3, 2));
        addRow("sw slt true", iInstr(isaOpSw, 8, 0, 20));
        addRow("slt r9 r2 r3", rInstr(isaFnSlt, 9, 2, 3));
        addRow("sw slt false", iInstr(isaOpSw, 9, 0, 24));
        addRow("addi r10 r1 -32768", iInstr(isaOpAddi, 10, 1, -32768));
        addRow("sw addi min imm", iInstr(isaOpSw, 10, 0, 28));
        addRow("lw r11 64", iInstr(isaOpLw, 11, 0, 64));
        addRow("add r12 load use", rInstr(isaFnAdd, 12, 11, 1));
        addRow("sw load use", iInstr(isaOpSw, 12, 0, 32));
        addRow("lw r13 103(r1)", iInstr(isaOpLw, 13, 1, 103));
        addRow("sw r13 after lw", iInstr(isaOpSw, 13, 0, 36));
        addRow("lw r14 stored word", iInstr(isaOpLw, 14, 0, 4));
        addRow("sw r14 72(r5)", iInstr(isaOpSw, 14, 5, 72));
        addRow("nop", 32'h0);
        addRow("add r15 r4 r4", rInstr(isaFnAdd, 15, 4, 4));
        addRow("sub r15 r15 r8", rInstr(isaFnSub, 15, 15, 8));
        addRow("sw chain", iInstr(isaOpSw, 15, 0, 44));
        addRow("addi r0 ignored", iInstr(isaOpAddi, 0, 1, 5));
        addRow("sw r0", iInstr(isaOpSw, 0, 0, 48));
        addRow("unknown opcode", {6'h3f, 5'd0, 5'd1, 16'h0005});
        addRow("sw r1 after unknown", iInstr(isaOpSw, 1, 0, 52));
    endtask

    // executes the table one instruction at a time
    task automatic runModel();
        word_t      regs [32];
        word_t      instr;
        word_t      imm;
        word_t      addr;
        word_t      result;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] dest;
        logic       writeEn;
        int         i;

        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (i = 0; i < memDepth; i++) begin
            refMem[i] = fillWord(i);
        end
        for (i = 0; i < rowCount; i++) begin
            instr   = rows[i].instr;
            rs      = instr[25:21];
            rt      = instr[20:16];
            rd      = instr[15:11];
            imm     = {{16{instr[15]}}, instr[15:0]};
            addr    = regs[rs] + imm;
            result  = '0;
            dest    = rt;
            writeEn = 1'b0;
            case (instr[31:26])
                isaOpR: begin
                    dest    = rd;
                    writeEn = 1'b1;
                    case (instr[5:0])
                        isaFnAdd: result = regs[rs] + regs[rt];
                        isaFnSub: result = regs[rs] - regs[rt];
                        isaFnAnd: result = regs[rs] & regs[rt];
                        isaFnOr:  result = regs[rs] | regs[rt];
                        isaFnSlt: result = ($signed(regs[rs]) < $signed(regs[rt])) ? 1 : 0;
                        default:  writeEn = 1'b0;
                    endcase
                end
                isaOpAddi: begin
                    result  = addr;
                    writeEn = 1'b1;
                end
                isaOpLw: begin
                    result  = refMem[addr[9:2]];
                    writeEn = 1'b1;
                    expectLoads++;
                end
                isaOpSw: begin
                    rows[i].expStore = 1'b1;
                    rows[i].expAddr  = addr[31:2];
                    rows[i].expData  = regs[rt];
                    refMem[addr[9:2]] = regs[rt];
                    storeRows[expectCount] = i;
                    expectCount++;
                end
                default: ;
            endcase
            if (writeEn && dest != 0) begin
                regs[dest] = result;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////

    task automatic compareWord(input string name, input string field, input word_t expected,
                               input word_t actual);
        checkCount++;
        assert (actual == expected) else begin
            errorCount++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     name, field, expected, actual);
        end
    endtask

    // stores must arrive once each and in program order
    task automatic checkStore();
        int r;

        checkCount++;
        assert (storeCount < expectCount) else begin
            errorCount++;
            $display("unexpected store after the last program store: address %h, data %h",
                     dCacheReq.addr, dCacheReq.wdata);
        end
        if (storeCount < expectCount) begin
            r = storeRows[storeCount];
            compareWord(rowNames[r], "store address", word_t'(rows[r].expAddr),
                        word_t'(dCacheReq.addr));
            compareWord(rowNames[r], "store data", rows[r].expData, dCacheReq.wdata);
        end
        storeCount <= storeCount + 1;
    endtask

    // data memory
    initial begin
        int i;

        for (i = 0; i < memDepth; i++) begin
            dataMem[i] = fillWord(i);
        end
        forever begin
            @(posedge clk);
            if (rst_n && dCacheReq.wen && !dCacheStall) begin
                dataMem[dCacheReq.addr[7:0]] <= dCacheReq.wdata;
                // request repeats while fetch stalls
                // so only an advancing edge counts
                if (!iCacheStall) begin
                    checkStore();
                end
            end
            // one read request per load on an advancing edge
            if (rst_n && dCacheReq.ren && !dCacheStall && !iCacheStall) begin
                loadCount++;
            end
        end
    end

    // random cache stalls, roughly one cycle in four
    initial begin
        iCacheStall = 1'b0;
        dCacheStall = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                iCacheStall <= ($random(seed) & 7) == 0;
                dCacheStall <= ($random(seed) & 7) == 0;
            end
        end
    end

    // eight cycles per program row
    initial begin
        @(posedge clk);
        while (cycleCount < rowCount * 8) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, %0d of %0d stores seen",
                 cycleCount, storeCount, expectCount);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        buildProgram();
        runModel();
        @(posedge clk);
        @(negedge clk);
        compareWord("reset", "dCacheReq.ren", '0, word_t'(dCacheReq.ren));
        compareWord("reset", "dCacheReq.wen", '0, word_t'(dCacheReq.wen));
        compareWord("reset", "iCacheAddr", '0, word_t'(iCacheAddr));
        @(posedge clk);
        rst_n <= 1'b1;
        while (storeCount < expectCount) begin
            @(posedge clk);
        end
        // extra stores would show up here
        repeat (drainCycles) @(posedge clk);
        compareWord("load requests", "count", word_t'(expectLoads), word_t'(loadCount));
        $display("stores %0d of %0d, checks %0d, errors %0d",
                 storeCount, expectCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
